//--- common/mul_pkg.sv
package mul_pkg;

    // Operand width of the integer pipeline.
    localparam int XLEN = 32;

    // Multiply operations of the M extension.
    // The encoding follows funct3 of the instruction, so the decoder can pass it
    // through unchanged.
    typedef enum logic [1:0] {
        MUL    = 2'd0,
        MULH   = 2'd1,
        MULHSU = 2'd2,
        MULHU  = 2'd3
    } mul_op_e;

    // States of the request/response controller.
    typedef enum logic [1:0] {
        CTRL_IDLE = 2'd0,
        CTRL_BUSY = 2'd1,
        CTRL_DONE = 2'd2
    } ctrl_state_e;

    // States shared by the signed wrapper and the iterative core.
    typedef enum logic {
        CORE_IDLE = 1'b0,
        CORE_RUN  = 1'b1
    } core_state_e;

endpackage

//--- mult/mult_unsigned.sv
`timescale 1ns/1ns

module mult_unsigned #(
    parameter int SIZE = mul_pkg::XLEN
) (
    input  logic                clk,
    input  logic                arst_n,

    input  logic                start,
    output logic                ready,
    output logic                valid,

    input  logic [SIZE-1:0]     multiplicand,
    input  logic [SIZE-1:0]     multiplier,
    output logic [2*SIZE-1:0]   product
);

    mul_pkg::core_state_e           state;
    logic [$clog2(SIZE+1)-1:0]      count_q;
    logic                           valid_q;
    logic [2*SIZE-1:0]              mcand_q;
    logic [SIZE-1:0]                mplier_q;
    logic [2*SIZE-1:0]              acc_q;
    logic                           load;
    logic                           step;

    assign load = (state == mul_pkg::CORE_IDLE) && start;

    // No step is taken in the valid cycle, so the product stays put there.
    assign step = (state == mul_pkg::CORE_RUN) && !valid_q;

    // Still busy during the valid cycle; ready returns on the edge after it.
    assign ready   = (state == mul_pkg::CORE_IDLE);
    assign valid   = valid_q;
    assign product = acc_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= mul_pkg::CORE_IDLE;
            count_q <= '0;
            valid_q <= 1'b0;
        end else begin
            case (state)
                mul_pkg::CORE_IDLE: begin
                    if (start) begin
                        state   <= mul_pkg::CORE_RUN;
                        count_q <= '0;
                    end
                end
                mul_pkg::CORE_RUN: begin
                    if (valid_q) begin
                        state   <= mul_pkg::CORE_IDLE;
                        valid_q <= 1'b0;
                    end else begin
                        count_q <= count_q + 1'b1;
                        // The last multiplier bit is added on this edge.
                        if (count_q == SIZE - 1) begin
                            valid_q <= 1'b1;
                        end
                    end
                end
                default: begin
                    state <= mul_pkg::CORE_IDLE;
                end
            endcase
        end
    end

    // Shift-add datapath, one multiplier bit per cycle from the LSB up.
    always_ff @(posedge clk) begin
        if (load) begin
            mcand_q  <= {{SIZE{1'b0}}, multiplicand};
            mplier_q <= multiplier;
            acc_q    <= '0;
        end else if (step) begin
            if (mplier_q[0]) begin
                acc_q <= acc_q + mcand_q;
            end
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

endmodule

//--- mult/mult_signed.sv
`timescale 1ns/1ns

module mult_signed #(
    parameter int SIZE = mul_pkg::XLEN
) (
    input  logic                clk,
    input  logic                arst_n,

    input  logic                start,
    input  logic                a_signed,
    input  logic                b_signed,
    output logic                ready,
    output logic                valid,

    input  logic [SIZE-1:0]     multiplicand,
    input  logic [SIZE-1:0]     multiplier,
    output logic [2*SIZE-1:0]   product
);

    mul_pkg::core_state_e   state;
    logic                   result_neg;
    logic                   a_neg;
    logic                   b_neg;
    logic [SIZE-1:0]        a_mag;
    logic [SIZE-1:0]        b_mag;
    logic [2*SIZE-1:0]      mag_product;

    // An operand only counts as negative when it is treated as signed.
    assign a_neg = a_signed && multiplicand[SIZE-1];
    assign b_neg = b_signed && multiplier[SIZE-1];

    // The most negative value maps onto 2**(SIZE-1), which is still exact
    // as an unsigned magnitude.
    assign a_mag = a_neg ? -multiplicand : multiplicand;
    assign b_mag = b_neg ? -multiplier   : multiplier;

    assign product = result_neg ? -mag_product : mag_product;

    mult_unsigned #(
        .SIZE (SIZE)
    ) core_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .start        (start),
        .ready        (ready),
        .valid        (valid),
        .multiplicand (a_mag),
        .multiplier   (b_mag),
        .product      (mag_product)
    );

    // The sign is sampled together with the operands, so the caller may
    // change its inputs while the core is running.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= mul_pkg::CORE_IDLE;
            result_neg <= 1'b0;
        end else begin
            case (state)
                mul_pkg::CORE_IDLE: begin
                    if (start) begin
                        state      <= mul_pkg::CORE_RUN;
                        result_neg <= a_neg ^ b_neg;
                    end
                end
                mul_pkg::CORE_RUN: begin
                    if (valid) begin
                        state <= mul_pkg::CORE_IDLE;
                    end
                end
                default: begin
                    state <= mul_pkg::CORE_IDLE;
                end
            endcase
        end
    end

endmodule

//--- source/mul_ctrl.sv
`timescale 1ns/1ns

module mul_ctrl (
    input  logic                       clk,
    input  logic                       arst_n,

    input  logic                       req_valid,
    output logic                       req_ready,
    input  mul_pkg::mul_op_e           req_op,
    input  logic [mul_pkg::XLEN-1:0]   req_a,
    input  logic [mul_pkg::XLEN-1:0]   req_b,

    output logic                       resp_valid,
    input  logic                       resp_ready,
    output logic [mul_pkg::XLEN-1:0]   resp_data,

    output logic                       start,
    output logic                       a_signed,
    output logic                       b_signed,
    output logic [mul_pkg::XLEN-1:0]   multiplicand,
    output logic [mul_pkg::XLEN-1:0]   multiplier,
    input  logic                       mul_valid,
    input  logic [2*mul_pkg::XLEN-1:0] product
);

    mul_pkg::ctrl_state_e       state;
    mul_pkg::mul_op_e           op_q;
    logic [mul_pkg::XLEN-1:0]   a_q;
    logic [mul_pkg::XLEN-1:0]   b_q;
    logic [mul_pkg::XLEN-1:0]   resp_q;
    logic                       start_q;
    logic                       accept;
    logic                       capture;

    assign req_ready = (state == mul_pkg::CTRL_IDLE);
    assign accept    = req_valid && req_ready;
    assign capture   = (state == mul_pkg::CTRL_BUSY) && mul_valid;

    // MUL only needs the low word, which is the same for any signedness,
    // so it runs as an unsigned multiply.
    assign a_signed = (op_q == mul_pkg::MULH) || (op_q == mul_pkg::MULHSU);
    assign b_signed = (op_q == mul_pkg::MULH);

    assign start        = start_q;
    assign multiplicand = a_q;
    assign multiplier   = b_q;
    assign resp_valid   = (state == mul_pkg::CTRL_DONE);
    assign resp_data    = resp_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= mul_pkg::CTRL_IDLE;
            start_q <= 1'b0;
        end else begin
            start_q <= 1'b0;
            case (state)
                mul_pkg::CTRL_IDLE: begin
                    if (req_valid) begin
                        state   <= mul_pkg::CTRL_BUSY;
                        start_q <= 1'b1;
                    end
                end
                mul_pkg::CTRL_BUSY: begin
                    if (mul_valid) begin
                        state <= mul_pkg::CTRL_DONE;
                    end
                end
                mul_pkg::CTRL_DONE: begin
                    // The response register holds its value until it is taken.
                    if (resp_ready) begin
                        state <= mul_pkg::CTRL_IDLE;
                    end
                end
                default: begin
                    state <= mul_pkg::CTRL_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q <= req_op;
            a_q  <= req_a;
            b_q  <= req_b;
        end
        if (capture) begin
            if (op_q == mul_pkg::MUL) begin
                resp_q <= product[mul_pkg::XLEN-1:0];
            end else begin
                resp_q <= product[2*mul_pkg::XLEN-1:mul_pkg::XLEN];
            end
        end
    end

endmodule

//--- source/mul_unit.sv
`timescale 1ns/1ns

module mul_unit (
    input  logic                     clk,
    input  logic                     arst_n,

    input  logic                     req_valid,
    output logic                     req_ready,
    input  mul_pkg::mul_op_e         req_op,
    input  logic [mul_pkg::XLEN-1:0] req_a,
    input  logic [mul_pkg::XLEN-1:0] req_b,

    output logic                     resp_valid,
    input  logic                     resp_ready,
    output logic [mul_pkg::XLEN-1:0] resp_data
);

    logic                         mul_start;
    logic                         mul_a_signed;
    logic                         mul_b_signed;
    logic [mul_pkg::XLEN-1:0]     mul_multiplicand;
    logic [mul_pkg::XLEN-1:0]     mul_multiplier;
    logic                         mul_valid;
    logic [2*mul_pkg::XLEN-1:0]   mul_product;

    mul_ctrl ctrl_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req_op       (req_op),
        .req_a        (req_a),
        .req_b        (req_b),
        .resp_valid   (resp_valid),
        .resp_ready   (resp_ready),
        .resp_data    (resp_data),
        .start        (mul_start),
        .a_signed     (mul_a_signed),
        .b_signed     (mul_b_signed),
        .multiplicand (mul_multiplicand),
        .multiplier   (mul_multiplier),
        .mul_valid    (mul_valid),
        .product      (mul_product)
    );

    // The controller only starts from its idle state, so the multiplier's
    // ready output is left open here.
    mult_signed #(
        .SIZE (mul_pkg::XLEN)
    ) mult_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .start        (mul_start),
        .a_signed     (mul_a_signed),
        .b_signed     (mul_b_signed),
        .ready        (),
        .valid        (mul_valid),
        .multiplicand (mul_multiplicand),
        .multiplier   (mul_multiplier),
        .product      (mul_product)
    );

endmodule

//--- verif/mul_unit_tb.sv
`timescale 1ns/1ns

module mul_unit_tb;

    localparam int XLEN         = mul_pkg::XLEN;
    localparam int LATENCY      = mul_pkg::XLEN + 2;
    localparam int ACCEPT_LIMIT = 200;
    localparam int DRAIN_LIMIT  = 4000;

    logic                clk;
    logic                arst_n;
    logic                req_valid;
    logic                req_ready;
    mul_pkg::mul_op_e    req_op;
    logic [XLEN-1:0]     req_a;
    logic [XLEN-1:0]     req_b;
    logic                resp_valid;
    logic                resp_ready;
    logic [XLEN-1:0]     resp_data;

    // Expected results and accept cycles of the requests still in flight.
    logic [XLEN-1:0]     exp_q[$];
    int                  accept_q[$];

    int                  cycle;
    int                  errors;
    int                  sent;
    int                  received;
    logic                bp_on;
    int                  hold_left;
    logic                resp_valid_d;
    logic                resp_ready_d;
    logic [XLEN-1:0]     resp_data_d;

    mul_unit dut_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_op     (req_op),
        .req_a      (req_a),
        .req_b      (req_b),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp_data  (resp_data)
    );

    always #2 clk = ~clk;

    // Extending each operand to the full product width with its own signedness
    // keeps the low 2*XLEN bits of the product exact.
    function automatic logic [XLEN-1:0] expected_result(input mul_pkg::mul_op_e op,
                                                        input logic [XLEN-1:0] a,
                                                        input logic [XLEN-1:0] b);
        logic [2*XLEN-1:0] ax;
        logic [2*XLEN-1:0] bx;
        logic [2*XLEN-1:0] p;
        if (op == mul_pkg::MULH || op == mul_pkg::MULHSU) begin
            ax = {{XLEN{a[XLEN-1]}}, a};
        end else begin
            ax = {{XLEN{1'b0}}, a};
        end
        if (op == mul_pkg::MULH) begin
            bx = {{XLEN{b[XLEN-1]}}, b};
        end else begin
            bx = {{XLEN{1'b0}}, b};
        end
        p = ax * bx;
        if (op == mul_pkg::MUL) begin
            return p[XLEN-1:0];
        end
        return p[2*XLEN-1:XLEN];
    endfunction

    task automatic end_run();
        $display("Requests %0d, responses %0d, errors %0d", sent, received, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    endtask

    // Called on a falling edge; returns on the falling edge after the accept.
    task automatic send_request(input mul_pkg::mul_op_e op,
                                input logic [XLEN-1:0] a,
                                input logic [XLEN-1:0] b);
        int waited;
        waited    = 0;
        req_valid = 1'b1;
        req_op    = op;
        req_a     = a;
        req_b     = b;
        while (!req_ready && waited < ACCEPT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!req_ready) begin
            errors++;
            $display("Timeout at %0t: the request was never accepted", $time);
            end_run();
        end else begin
            @(negedge clk);
            req_valid = 1'b0;
        end
    endtask

    task automatic send_random_batch(input int count);
        logic [31:0] rnd;
        for (int i = 0; i < count; i++) begin
            rnd = $urandom;
            send_request(mul_pkg::mul_op_e'(rnd[1:0]), $urandom, $urandom);
        end
    endtask

    task automatic drain_responses();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("Timeout at %0t: %0d responses never arrived", $time, exp_q.size());
            end_run();
        end
    endtask

    task automatic set_backpressure(input logic on);
        @(posedge clk);
        bp_on = on;
        @(negedge clk);
    endtask

    // Consumer side; resp_ready toggles with random stretch lengths.
    always @(negedge clk) begin
        if (!bp_on) begin
            resp_ready = 1'b1;
            hold_left  = 0;
        end else if (hold_left == 0) begin
            resp_ready = !resp_ready;
            hold_left  = int'($urandom % 16) + 1;
        end else begin
            hold_left--;
        end
    end

    always @(posedge clk) begin : monitor
        int              lat;
        logic [XLEN-1:0] head;
        cycle++;
        if (arst_n) begin
            if (req_valid && req_ready) begin
                exp_q.push_back(expected_result(req_op, req_a, req_b));
                accept_q.push_back(cycle);
                sent++;
            end
            // resp_valid rose on the edge before this one.
            if (resp_valid && !resp_valid_d) begin
                if (accept_q.size() == 0) begin
                    errors++;
                    $display("Error at %0t: resp_valid rose with no request in flight", $time);
                end else begin
                    lat = cycle - accept_q.pop_front() - 1;
                    assert (lat == LATENCY) else begin
                        errors++;
                        $display("FAILED time=%0t signal=resp_valid latency expected=%0d actual=%0d",
                                 $time, LATENCY, lat);
                    end
                end
            end
            if (resp_valid_d && !resp_ready_d) begin
                assert (resp_valid) else begin
                    errors++;
                    $display("FAILED time=%0t signal=resp_valid expected=1 actual=%b",
                             $time, resp_valid);
                end
                assert (resp_data === resp_data_d) else begin
                    errors++;
                    $display("FAILED time=%0t signal=resp_data expected=%h actual=%h",
                             $time, resp_data_d, resp_data);
                end
            end
            if (resp_valid) begin
                assert (!req_ready) else begin
                    errors++;
                    $display("FAILED time=%0t signal=req_ready expected=0 actual=%b",
                             $time, req_ready);
                end
            end
            if (resp_valid && resp_ready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Error at %0t: a response was taken that no request asked for",
                             $time);
                end else begin
                    head = exp_q.pop_front();
                    received++;
                    assert (resp_data === head) else begin
                        errors++;
                        $display("FAILED time=%0t signal=resp_data expected=%h actual=%h",
                                 $time, head, resp_data);
                    end
                end
            end
        end
        resp_valid_d = resp_valid;
        resp_ready_d = resp_ready;
        resp_data_d  = resp_data;
    end

    initial begin
        logic [XLEN-1:0] ra;
        logic [XLEN-1:0] rb;
        void'($urandom(32'h95b28e6a));
        clk          = 1'b0;
        arst_n       = 1'b0;
        req_valid    = 1'b0;
        req_op       = mul_pkg::MUL;
        req_a        = '0;
        req_b        = '0;
        resp_ready   = 1'b1;
        bp_on        = 1'b0;
        hold_left    = 0;
        cycle        = 0;
        errors       = 0;
        sent         = 0;
        received     = 0;
        resp_valid_d = 1'b0;
        resp_ready_d = 1'b1;
        resp_data_d  = '0;

        repeat (10) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        assert (req_ready === 1'b1) else begin
            errors++;
            $display("FAILED time=%0t signal=req_ready expected=1 actual=%b", $time, req_ready);
        end
        assert (resp_valid === 1'b0) else begin
            errors++;
            $display("FAILED time=%0t signal=resp_valid expected=0 actual=%b", $time, resp_valid);
        end

        for (int i = 0; i < 6; i++) begin
            send_request(mul_pkg::MUL, $urandom, $urandom);
        end
        send_request(mul_pkg::MUL, '0, $urandom);
        send_request(mul_pkg::MUL, $urandom, '0);
        send_request(mul_pkg::MUL, '0, '0);

        send_request(mul_pkg::MULH, 32'h8000_0000, 32'h8000_0000);
        send_request(mul_pkg::MULH, 32'hffff_ffff, 32'h0000_0001);
        send_request(mul_pkg::MULH, 32'h0000_0001, 32'hffff_ffff);
        send_request(mul_pkg::MULH, 32'h8000_0000, 32'h7fff_ffff);
        send_request(mul_pkg::MULH, 32'hffff_fff9, 32'h0000_0005);
        send_request(mul_pkg::MULH, 32'h7fff_ffff, 32'h7fff_ffff);

        // Top bits set, so the three high-word variants all differ.
        for (int i = 0; i < 4; i++) begin
            ra = $urandom | 32'h8000_0000;
            rb = $urandom | 32'h8000_0000;
            send_request(mul_pkg::MULH, ra, rb);
            send_request(mul_pkg::MULHSU, ra, rb);
            send_request(mul_pkg::MULHU, ra, rb);
        end
        drain_responses();

        set_backpressure(1'b1);
        send_random_batch(16);
        drain_responses();

        set_backpressure(1'b0);
        send_random_batch(10);
        drain_responses();

        // Every expected response was taken, so no response may still be offered.
        assert (resp_valid === 1'b0) else begin
            errors++;
            $display("FAILED time=%0t signal=resp_valid expected=0 actual=%b", $time, resp_valid);
        end
        end_run();
    end

endmodule

//--- compile.f
common/mul_pkg.sv
mult/mult_unsigned.sv
mult/mult_signed.sv
source/mul_ctrl.sv
source/mul_unit.sv
verif/mul_unit_tb.sv

//--- Makefile
# Verilator simulation of the multiply unit.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= mul_unit_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= SIMULATION PASSED
VFLAGS    ?= --binary --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx '$(PASS_MSG)' $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
